/* logic/cdc_pkg.sv */
////////////////////////////////////////////////////////////
// shared widths and types for the dual channel cdc bridge
// tag 0 is channel a, tag 1 is channel b
// sync_stages below 2 is not a valid synchronizer
////////////////////////////////////////////////////////////

package cdc_pkg;

  // sample width, both channels
  localparam int data_w = 16;

  // destination flops per bit synchronizer
  localparam int sync_stages = 2;

  typedef logic [data_w-1:0] data_t;  // one sample
  typedef logic [0:0]        chan_t;  // channel tag

  localparam chan_t chan_a = 1'b0;
  localparam chan_t chan_b = 1'b1;

  // one merged output beat, 17 bits
  typedef struct packed {
    chan_t tag;   // source channel
    data_t data;  // sample as captured on the source side
  } merged_beat_t;

endpackage

/* logic/cdc_bit_sync.sv */
////////////////////////////////////////////////////////////
// single bit crossing, source flop plus dst flop chain
// only for level or toggle signals, never for pulses
// each side resets to zero on its own reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cdc_bit_sync (
  input  logic clk_src,
  input  logic rst_src_n,
  input  logic clk_dst,
  input  logic rst_dst_n,
  input  logic src_bit,
  output logic dst_bit
);

  import cdc_pkg::*;

  logic                   src_q;      // glitch free launch point
  logic [sync_stages-1:0] dst_chain;  // metastability filter

  always_ff @(posedge clk_src or negedge rst_src_n) begin
    if (!rst_src_n) src_q <= 1'b0;
    else            src_q <= src_bit;
  end

  // first flop may go metastable, rest of the chain settles it
  always_ff @(posedge clk_dst or negedge rst_dst_n) begin
    if (!rst_dst_n) dst_chain <= '0;
    else            dst_chain <= {dst_chain[sync_stages-2:0], src_q};
  end

  assign dst_bit = dst_chain[sync_stages-1];  // last stage only

endmodule

`default_nettype wire

/* logic/cdc_vector_sync.sv */
////////////////////////////////////////////////////////////
// toggle handshake crossing of one vector, one item in flight
// src_vector_q must stay stable until the ack toggle returns
// either side idles while it sees the other side in reset
// throughput is one item per full req/ack round trip
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cdc_vector_sync #(
  parameter int data_width = cdc_pkg::data_w
) (
  input  logic                  clk_src,
  input  logic                  rst_src_n,
  input  logic                  clk_dst,
  input  logic                  rst_dst_n,
  // source side stream
  input  logic [data_width-1:0] ing_vector,
  input  logic                  ing_valid,
  output logic                  ing_ready,
  // destination side stream
  output logic [data_width-1:0] egr_vector,
  output logic                  egr_valid,
  input  logic                  egr_ready
);

  typedef enum logic {src_idle, src_wait_ack}   src_state_t;
  typedef enum logic {dst_idle, dst_wait_ready} dst_state_t;

  src_state_t src_state;
  dst_state_t dst_state;

  logic [data_width-1:0] src_vector_q;  // held for the dst side to sample

  logic src_partner_up;  // dst out of reset, seen from src
  logic dst_partner_up;  // src out of reset, seen from dst

  logic src_req;     // flips once per accepted sample
  logic dst_req;     // synchronized copy
  logic dst_req_d0;  // for edge detect
  logic dst_ack;     // flips once per delivered sample
  logic src_ack;     // synchronized copy
  logic src_ack_d0;

  logic src_accept;
  logic dst_new_req;

  assign src_accept  = ing_valid && ing_ready && src_partner_up;
  assign dst_new_req = dst_partner_up && (dst_state == dst_idle) && (dst_req != dst_req_d0);

  ////////////////////////////////////////////////////////////
  // source domain
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_src or negedge rst_src_n) begin
    if (!rst_src_n) begin
      src_state  <= src_idle;
      ing_ready  <= 1'b0;
      src_req    <= 1'b0;
      src_ack_d0 <= 1'b0;
    end else begin
      src_ack_d0 <= src_ack;  // tracks even in partner reset, no stale edge
      if (!src_partner_up) begin
        // dst side in reset, drop everything
        src_state <= src_idle;
        ing_ready <= 1'b0;
        src_req   <= 1'b0;
      end else begin
        case (src_state)
          src_idle: begin
            ing_ready <= 1'b1;
            if (src_accept) begin
              src_state <= src_wait_ack;
              src_req   <= ~src_req;  // announce new sample
              ing_ready <= 1'b0;
            end
          end
          src_wait_ack: begin
            if (src_ack != src_ack_d0) begin  // dst has taken it
              src_state <= src_idle;
              ing_ready <= 1'b1;
            end
          end
          default: src_state <= src_idle;
        endcase
      end
    end
  end

  // payload capture
  always_ff @(posedge clk_src) begin
    if (src_accept) src_vector_q <= ing_vector;
  end

  ////////////////////////////////////////////////////////////
  // destination domain
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_dst or negedge rst_dst_n) begin
    if (!rst_dst_n) begin
      dst_state  <= dst_idle;
      egr_valid  <= 1'b0;
      dst_req_d0 <= 1'b0;
      dst_ack    <= 1'b0;
    end else begin
      dst_req_d0 <= dst_req;
      if (!dst_partner_up) begin
        // src side in reset, matches its cleared req toggle
        dst_state <= dst_idle;
        egr_valid <= 1'b0;
        dst_ack   <= 1'b0;
      end else begin
        case (dst_state)
          dst_idle: begin
            if (dst_new_req) begin
              dst_state <= dst_wait_ready;
              egr_valid <= 1'b1;
            end
          end
          dst_wait_ready: begin
            if (egr_ready) begin
              dst_state <= dst_idle;
              egr_valid <= 1'b0;
              dst_ack   <= ~dst_ack;  // release the src side
            end
          end
          default: dst_state <= dst_idle;
        endcase
      end
    end
  end

  // src_vector_q is stable here, req edge came through the sync chain
  always_ff @(posedge clk_dst) begin
    if (dst_new_req) egr_vector <= src_vector_q;
  end

  ////////////////////////////////////////////////////////////
  // bit crossings
  ////////////////////////////////////////////////////////////

  cdc_bit_sync src_rst_to_dst (  // src reset state into dst
    .clk_src   (clk_src),
    .rst_src_n (rst_src_n),
    .clk_dst   (clk_dst),
    .rst_dst_n (rst_dst_n),
    .src_bit   (1'b1),
    .dst_bit   (dst_partner_up)
  );

  cdc_bit_sync dst_rst_to_src (  // dst reset state into src
    .clk_src   (clk_dst),
    .rst_src_n (rst_dst_n),
    .clk_dst   (clk_src),
    .rst_dst_n (rst_src_n),
    .src_bit   (1'b1),
    .dst_bit   (src_partner_up)
  );

  cdc_bit_sync req_sync (
    .clk_src   (clk_src),
    .rst_src_n (rst_src_n),
    .clk_dst   (clk_dst),
    .rst_dst_n (rst_dst_n),
    .src_bit   (src_req),
    .dst_bit   (dst_req)
  );

  cdc_bit_sync ack_sync (
    .clk_src   (clk_dst),
    .rst_src_n (rst_dst_n),
    .clk_dst   (clk_src),
    .rst_dst_n (rst_src_n),
    .src_bit   (dst_ack),
    .dst_bit   (src_ack)
  );

endmodule

`default_nettype wire

/* logic/stream_merge.sv */
////////////////////////////////////////////////////////////
// two into one round robin merge with a one entry output reg
// readies are combinational from valid and out_ready
// refills in the same cycle the output beat leaves
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module stream_merge (
  input  logic                 clk_dst,
  input  logic                 rst_dst_n,
  input  cdc_pkg::data_t       a_data,
  input  logic                 a_valid,
  output logic                 a_ready,
  input  cdc_pkg::data_t       b_data,
  input  logic                 b_valid,
  output logic                 b_ready,
  output cdc_pkg::merged_beat_t out_beat,
  output logic                 out_valid,
  input  logic                 out_ready
);

  import cdc_pkg::*;

  typedef enum logic {slot_empty, slot_full} slot_state_t;

  slot_state_t slot_state;
  chan_t       last_grant;  // channel loaded last time

  logic slot_free;  // empty now, or emptying this cycle
  logic grant_a;
  logic grant_b;
  logic take;       // an input transfer happens

  assign slot_free = (slot_state == slot_empty) || out_ready;

  // b wins a tie only if a went last
  assign grant_b = b_valid && (!a_valid || (last_grant == chan_a));
  assign grant_a = a_valid && !grant_b;

  assign a_ready = slot_free && grant_a;
  assign b_ready = slot_free && grant_b;
  assign take    = a_ready || b_ready;

  assign out_valid = (slot_state == slot_full);

  always_ff @(posedge clk_dst or negedge rst_dst_n) begin
    if (!rst_dst_n) begin
      slot_state <= slot_empty;
      last_grant <= chan_b;  // a goes first after reset
    end else begin
      if (take) begin
        slot_state <= slot_full;
        last_grant <= grant_b ? chan_b : chan_a;
      end else if (out_ready) begin
        slot_state <= slot_empty;  // beat left, nothing new
      end
    end
  end

  // beat payload, holds while stalled
  always_ff @(posedge clk_dst) begin
    if (take) begin
      out_beat.tag  <= grant_b ? chan_b : chan_a;
      out_beat.data <= grant_b ? b_data : a_data;
    end
  end

endmodule

`default_nettype wire

/* logic/cdc_dual_bridge.sv */
////////////////////////////////////////////////////////////
// two src streams crossed into clk_dst and merged
// order is kept per channel only, latency varies
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cdc_dual_bridge (
  // source domain
  input  logic                  clk_src,
  input  logic                  rst_src_n,
  input  cdc_pkg::data_t        a_vector,
  input  logic                  a_valid,
  output logic                  a_ready,
  input  cdc_pkg::data_t        b_vector,
  input  logic                  b_valid,
  output logic                  b_ready,
  // destination domain
  input  logic                  clk_dst,
  input  logic                  rst_dst_n,
  output cdc_pkg::merged_beat_t out_beat,
  output logic                  out_valid,
  input  logic                  out_ready
);

  import cdc_pkg::*;

  data_t a_egr_vector;  // channel a after crossing
  logic  a_egr_valid;
  logic  a_egr_ready;
  data_t b_egr_vector;  // channel b after crossing
  logic  b_egr_valid;
  logic  b_egr_ready;

  cdc_vector_sync #(.data_width(data_w)) sync_a (
    .clk_src    (clk_src),
    .rst_src_n  (rst_src_n),
    .clk_dst    (clk_dst),
    .rst_dst_n  (rst_dst_n),
    .ing_vector (a_vector),
    .ing_valid  (a_valid),
    .ing_ready  (a_ready),
    .egr_vector (a_egr_vector),
    .egr_valid  (a_egr_valid),
    .egr_ready  (a_egr_ready)
  );

  cdc_vector_sync #(.data_width(data_w)) sync_b (
    .clk_src    (clk_src),
    .rst_src_n  (rst_src_n),
    .clk_dst    (clk_dst),
    .rst_dst_n  (rst_dst_n),
    .ing_vector (b_vector),
    .ing_valid  (b_valid),
    .ing_ready  (b_ready),
    .egr_vector (b_egr_vector),
    .egr_valid  (b_egr_valid),
    .egr_ready  (b_egr_ready)
  );

  stream_merge merge (
    .clk_dst   (clk_dst),
    .rst_dst_n (rst_dst_n),
    .a_data    (a_egr_vector),
    .a_valid   (a_egr_valid),
    .a_ready   (a_egr_ready),
    .b_data    (b_egr_vector),
    .b_valid   (b_egr_valid),
    .b_ready   (b_egr_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

/* tb/cdc_dual_bridge_assertions.sv */
////////////////////////////////////////////////////////////
// port level properties, bound into cdc_dual_bridge
// reset rules hold while either domain is in reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cdc_dual_bridge_assertions (
  input logic                  clk_src,
  input logic                  rst_src_n,
  input logic                  clk_dst,
  input logic                  rst_dst_n,
  input logic                  a_valid,
  input logic                  a_ready,
  input logic                  b_valid,
  input logic                  b_ready,
  input cdc_pkg::merged_beat_t out_beat,
  input logic                  out_valid,
  input logic                  out_ready
);

  // nothing offered on either side during reset
  dst_quiet_in_reset: assert property (@(posedge clk_dst)
    (!rst_dst_n || !rst_src_n) |-> !out_valid)
    else $error("out_valid high while a reset is asserted");

  src_quiet_in_reset: assert property (@(posedge clk_src)
    (!rst_src_n || !rst_dst_n) |-> (!a_ready && !b_ready))
    else $error("source ready high while a reset is asserted");

  // output register holds under back-pressure
  beat_held_on_stall: assert property (@(posedge clk_dst) disable iff (!rst_dst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else $error("out_beat changed or out_valid fell during a stall");

  // one sample in flight per channel
  a_ready_drops: assert property (@(posedge clk_src) disable iff (!rst_src_n)
    (a_valid && a_ready) |=> !a_ready)
    else $error("a_ready stayed high after an accepted sample");

  b_ready_drops: assert property (@(posedge clk_src) disable iff (!rst_src_n)
    (b_valid && b_ready) |=> !b_ready)
    else $error("b_ready stayed high after an accepted sample");

endmodule

/* tb/cdc_dual_bridge_checker.sv */
////////////////////////////////////////////////////////////
// watches the bridge ports with one queue per channel
// checks ordering inside a channel but not latency
// fair_check enables the run length rule for saturated sources
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cdc_dual_bridge_checker (
  input  logic                  clk_src,
  input  logic                  rst_src_n,
  input  logic                  clk_dst,
  input  logic                  rst_dst_n,
  input  cdc_pkg::data_t        a_vector,
  input  logic                  a_valid,
  input  logic                  a_ready,
  input  cdc_pkg::data_t        b_vector,
  input  logic                  b_valid,
  input  logic                  b_ready,
  input  cdc_pkg::merged_beat_t out_beat,
  input  logic                  out_valid,
  input  logic                  out_ready,
  input  logic                  fair_check,
  output int                    pushed,
  output int                    popped,
  output int                    src_errors,
  output int                    dst_errors
);

  import cdc_pkg::*;

  data_t        qa[$];  // accepted but not yet seen at the output
  data_t        qb[$];
  merged_beat_t held_beat;
  logic         stalled = 1'b0;
  logic         a_taken = 1'b0;  // accepted on the previous clk_src edge
  logic         b_taken = 1'b0;
  chan_t        last_tag = chan_a;
  int           run_len = 0;
  int           n_pushed = 0;
  int           n_popped = 0;
  int           n_src_err = 0;
  int           n_dst_err = 0;

  assign pushed     = n_pushed;
  assign popped     = n_popped;
  assign src_errors = n_src_err;
  assign dst_errors = n_dst_err;

  // expected beat for a tag from the head of its queue
  function automatic merged_beat_t expected_beat(input chan_t tag);
    merged_beat_t exp;
    exp.tag  = tag;
    exp.data = (tag == chan_b) ? qb[0] : qa[0];
    return exp;
  endfunction

  always @(posedge clk_src) begin
    int n;
    n = 0;
    if (!rst_src_n || !rst_dst_n) begin
      if (a_ready || b_ready) begin
        $display("CHECK FAILED a_ready/b_ready in reset: got %h/%h expected 0/0",
                 a_ready, b_ready);
        n_src_err++;
      end
      a_taken = 1'b0;
      b_taken = 1'b0;
    end else begin
      // ready falls after each accept
      if (a_taken && a_ready) begin
        $display("CHECK FAILED a_ready after accept: got %h expected 0", a_ready);
        n_src_err++;
      end
      if (b_taken && b_ready) begin
        $display("CHECK FAILED b_ready after accept: got %h expected 0", b_ready);
        n_src_err++;
      end
      a_taken = a_valid && a_ready;
      b_taken = b_valid && b_ready;
      if (a_valid && a_ready) begin
        qa.push_back(a_vector);
        n++;
      end
      if (b_valid && b_ready) begin
        qb.push_back(b_vector);
        n++;
      end
      n_pushed <= n_pushed + n;
    end
  end

  always @(posedge clk_dst) begin
    merged_beat_t exp;
    if (!rst_dst_n || !rst_src_n) begin
      if (out_valid) begin
        $display("CHECK FAILED out_valid in reset: got %h expected 0", out_valid);
        n_dst_err++;
      end
      stalled = 1'b0;
    end else begin
      if (stalled && !out_valid) begin
        $display("CHECK FAILED out_valid under stall: got %h expected 1", out_valid);
        n_dst_err++;
      end else if (stalled && (out_beat != held_beat)) begin
        $display("CHECK FAILED out_beat under stall: got %h expected %h", out_beat, held_beat);
        n_dst_err++;
      end
      if (out_valid && out_ready) begin
        if ((out_beat.tag == chan_b) ? (qb.size() == 0) : (qa.size() == 0)) begin
          $display("beat with tag %0d came out but nothing was pending on it", out_beat.tag);
          n_dst_err++;
        end else begin
          exp = expected_beat(out_beat.tag);
          if (out_beat != exp) begin
            $display("CHECK FAILED out_beat: got %h expected %h", out_beat, exp);
            n_dst_err++;
          end
          run_len  = (fair_check && out_beat.tag == last_tag) ? run_len + 1 : 1;
          last_tag = out_beat.tag;
          if (run_len > 2 && ((out_beat.tag == chan_b) ? qa.size() : qb.size()) != 0) begin
            $display("%0d beats in a row on channel %0d while the other one waited",
                     run_len, out_beat.tag);
            n_dst_err++;
          end
          if (out_beat.tag == chan_b) void'(qb.pop_front());
          else                        void'(qa.pop_front());
          n_popped <= n_popped + 1;
        end
      end
      stalled   = out_valid && !out_ready;
      held_beat = out_beat;
    end
  end

endmodule

/* tb/tb_cdc_dual_bridge.sv */
////////////////////////////////////////////////////////////
// testbench top for the dual channel cdc bridge
// clk_src 14 ns and clk_dst 10 ns, unrelated phases
// sources and out_ready are driven with NBAs on their own edge
// checker and bound assertions do all the comparing
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cdc_dual_bridge;

  import cdc_pkg::*;

  localparam int single_n   = 20;   // per channel, one channel at a time
  localparam int mixed_n    = 100;  // per channel, both channels
  localparam int fair_n     = 40;   // per channel, sources saturated
  localparam int planned    = 2 * single_n + 4 * mixed_n + 2 * fair_n;
  localparam int timeout_ns = planned * 200 * 10 + 5000;

  logic         clk_src;
  logic         rst_src_n;
  logic         clk_dst;
  logic         rst_dst_n;
  data_t        a_vector;
  logic         a_valid;
  logic         a_ready;
  data_t        b_vector;
  logic         b_valid;
  logic         b_ready;
  merged_beat_t out_beat;
  logic         out_valid;
  logic         out_ready;

  logic stall_on;  // random out_ready stalls
  logic fair_on;   // run length check in the checker
  int   seed = 32'hba11;
  int   pushed;
  int   popped;
  int   src_errors;
  int   dst_errors;
  int   tests_done = 0;
  int   popped_mark = 0;
  int   errors_mark = 0;

  cdc_dual_bridge DUT (.*);

  cdc_dual_bridge_checker chk (
    .clk_src    (clk_src),
    .rst_src_n  (rst_src_n),
    .clk_dst    (clk_dst),
    .rst_dst_n  (rst_dst_n),
    .a_vector   (a_vector),
    .a_valid    (a_valid),
    .a_ready    (a_ready),
    .b_vector   (b_vector),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .fair_check (fair_on),
    .pushed     (pushed),
    .popped     (popped),
    .src_errors (src_errors),
    .dst_errors (dst_errors)
  );

  bind cdc_dual_bridge cdc_dual_bridge_assertions port_props (
    .clk_src   (clk_src),
    .rst_src_n (rst_src_n),
    .clk_dst   (clk_dst),
    .rst_dst_n (rst_dst_n),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  ////////////////////////////////////////////////////////////
  // clocks, resets, sink side
  ////////////////////////////////////////////////////////////

  initial begin
    clk_dst = 1'b0;
    forever #5 clk_dst = ~clk_dst;
  end

  initial begin
    clk_src = 1'b0;
    forever #7 clk_src = ~clk_src;
  end

  initial begin
    rst_dst_n = 1'b0;
    repeat (10) @(posedge clk_dst);
    rst_dst_n <= 1'b1;
  end

  initial begin
    rst_src_n = 1'b0;
    repeat (10) @(posedge clk_src);  // released after dst side
    rst_src_n <= 1'b1;
  end

  initial begin
    logic [31:0] r;
    forever begin
      @(posedge clk_dst);
      r = $random(seed);
      out_ready <= stall_on ? (r[1:0] != 2'b00) : 1'b1;  // stall one cycle in four
    end
  end

  initial begin
    #(timeout_ns);
    $display("watchdog: run did not finish within %0d ns", timeout_ns);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // source side
  ////////////////////////////////////////////////////////////

  // one channel, holds vector and valid until the accepting edge
  task automatic drive_source(input bit ch, input int count, input bit gaps);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      if (gaps) repeat (r[1:0]) @(posedge clk_src);  // idle 0..3 cycles
      r = $random(seed);
      if (ch) begin
        b_vector <= data_t'(r);
        b_valid  <= 1'b1;
      end else begin
        a_vector <= data_t'(r);
        a_valid  <= 1'b1;
      end
      @(posedge clk_src);
      while (!(ch ? b_ready : a_ready)) @(posedge clk_src);
      if (ch) b_valid <= 1'b0;
      else    a_valid <= 1'b0;
    end
  endtask

  // until every accepted sample has come out
  task automatic drain_outputs();
    repeat (2) @(posedge clk_dst);
    while (popped != pushed) @(posedge clk_dst);
  endtask

  task automatic run_sources(input int na, input int nb, input bit gaps);
    @(posedge clk_src);
    fork
      drive_source(1'b0, na, gaps);
      drive_source(1'b1, nb, gaps);
    join
    drain_outputs();
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = src_errors + dst_errors;
    $display("test %s done: %0d beats checked, %0d errors",
             name, popped - popped_mark, errs - errors_mark);
    popped_mark = popped;
    errors_mark = errs;
    tests_done++;
  endtask

  initial begin
    int errs;
    a_vector  = '0;
    a_valid   = 1'b0;
    b_vector  = '0;
    b_valid   = 1'b0;
    out_ready = 1'b1;
    stall_on  = 1'b0;
    fair_on   = 1'b0;

    wait (rst_src_n && rst_dst_n);
    @(posedge clk_src);
    while (!(a_ready && b_ready)) @(posedge clk_src);  // both partners seen
    finish_test("reset_state");

    run_sources(single_n, 0, 1'b1);
    finish_test("single_a");
    run_sources(0, single_n, 1'b1);
    finish_test("single_b");
    run_sources(mixed_n, mixed_n, 1'b1);
    finish_test("both_channels");

    stall_on <= 1'b1;
    run_sources(mixed_n, mixed_n, 1'b1);
    stall_on <= 1'b0;
    finish_test("back_pressure");

    fair_on <= 1'b1;
    run_sources(fair_n, fair_n, 1'b0);  // both valid all the time
    fair_on <= 1'b0;
    finish_test("fairness");

    errs = src_errors + dst_errors;
    $display("summary: %0d tests, %0d samples sent, %0d beats checked, %0d errors",
             tests_done, pushed, popped, errs);
    if (errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
logic/cdc_pkg.sv
logic/cdc_bit_sync.sv
logic/cdc_vector_sync.sv
logic/stream_merge.sv
logic/cdc_dual_bridge.sv
tb/cdc_dual_bridge_assertions.sv
tb/cdc_dual_bridge_checker.sv
tb/tb_cdc_dual_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cdc bridge testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module tb_cdc_dual_bridge -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test OK$" "$log"; then
  exit 0
fi
exit 1
